//--- rtl/cachePkg.sv
// Data cache package
// Geometry, field types and controller states shared by the cache blocks

package cachePkg;

    // ------------------------------------------------------------------------
    // Geometry
    // ------------------------------------------------------------------------

    // Words in one block, one bus beat each
    localparam int wordsPerBlock = 4;
    // Sets per way
    localparam int numSets = 2;
    // Word offset field, sized to wordsPerBlock
    localparam int offsetBits = 2;
    // Set index field
    localparam int setBits = $clog2(numSets);
    // Remaining address bits above byte, word and set fields
    localparam int tagBits = 30 - offsetBits - setBits;

    // ------------------------------------------------------------------------
    // Field types
    // ------------------------------------------------------------------------

    typedef logic [31:0] addrT;
    typedef logic [31:0] wordT;
    // One enable per byte lane of a store
    typedef logic [3:0] byteMaskT;
    typedef logic [tagBits-1:0] tagT;
    typedef logic [setBits-1:0] setT;
    // Word within a block, doubles as the bus beat number
    typedef logic [offsetBits-1:0] offsetT;

    // Miss sequence of the controller
    typedef enum logic [1:0] {
        idle,
        writeBack,
        fill,
        finish
    } cacheStateT;

endpackage

//--- rtl/cacheWay.sv
// One way of the data cache
// Per-set valid, dirty and tag bits plus block storage, with masked word writes

`timescale 1ns/1ps

module cacheWay (
    input  logic              clk,
    input  logic              reset,
    input  cachePkg::setT     set,
    input  cachePkg::offsetT  wordSel,
    input  logic              writeEnable,
    input  logic              fillWrite,
    input  logic              markDirty,
    input  cachePkg::tagT     newTag,
    input  cachePkg::wordT    storeWord,
    input  cachePkg::byteMaskT byteMask,
    output logic              valid,
    output logic              dirty,
    output cachePkg::tagT     tag,
    output cachePkg::wordT    word
);

    import cachePkg::*;

    // Status bits, one per set
    logic [numSets-1:0] validBits;
    logic [numSets-1:0] dirtyBits;

    // Tag and data arrays
    tagT  tags [numSets];
    wordT blocks [numSets][wordsPerBlock];

    // ------------------------------------------------------------------------
    // Read side, purely combinational
    // ------------------------------------------------------------------------

    assign valid = validBits[set];
    assign dirty = dirtyBits[set];
    assign tag   = tags[set];
    assign word  = blocks[set][wordSel];

    // ------------------------------------------------------------------------
    // Write side
    // ------------------------------------------------------------------------

    // Valid and dirty tracking
    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            validBits <= '0;
            dirtyBits <= '0;
        end else if (writeEnable) begin
            if (fillWrite) begin
                // Fresh block from memory is clean
                validBits[set] <= 1'b1;
                dirtyBits[set] <= 1'b0;
            end else if (markDirty) begin
                dirtyBits[set] <= 1'b1;
            end
        end
    end

    // Tag follows each refill beat
    always_ff @(posedge clk) begin
        if (writeEnable && fillWrite) begin
            tags[set] <= newTag;
        end
    end

    // Block data
    // Refill writes all four lanes, a store only the enabled ones
    always_ff @(posedge clk) begin
        if (writeEnable) begin
            for (int i = 0; i < 4; i++) begin
                if (fillWrite || byteMask[i]) begin
                    blocks[set][wordSel][8*i +: 8] <= storeWord[8*i +: 8];
                end
            end
        end
    end

endmodule

//--- rtl/wayReplace.sv
// Hit detection and replacement for the two-way cache
// Compares tags, keeps one LRU bit per set and picks the way to access

`timescale 1ns/1ps

module wayReplace (
    input  logic          clk,
    input  logic          reset,
    input  cachePkg::setT set,
    input  cachePkg::tagT addrTag,
    input  cachePkg::tagT tag1,
    input  cachePkg::tagT tag2,
    input  logic          valid1,
    input  logic          valid2,
    input  logic          dirty1,
    input  logic          dirty2,
    input  logic          write1,
    input  logic          write2,
    output logic          hit,
    output logic          hitWay1,
    output logic          way1En,
    output logic          way2En,
    output logic          victimDirty,
    output cachePkg::tagT victimTag
);

    import cachePkg::*;

    // High means way 2 is the one to replace next
    logic [numSets-1:0] lru;
    logic hitWay2;

    // Tag match qualified by valid
    assign hitWay1 = valid1 && (addrTag == tag1);
    assign hitWay2 = valid2 && (addrTag == tag2);
    assign hit     = hitWay1 || hitWay2;

    // ------------------------------------------------------------------------
    // Way choice
    // ------------------------------------------------------------------------

    always_comb begin
        if (hit) begin
            way1En = hitWay1;
            way2En = hitWay2;
        end else if (valid1 ^ valid2) begin
            // Fill the one empty way first
            way1En = !valid1;
            way2En = !valid2;
        end else begin
            // Both empty or both full
            way1En = !lru[set];
            way2En = lru[set];
        end
    end

    // Victim details for the write-back
    assign victimDirty = way1En ? dirty1 : dirty2;
    assign victimTag   = way1En ? tag1 : tag2;

    // ------------------------------------------------------------------------
    // LRU table
    // ------------------------------------------------------------------------

    // Point at the way that was not written
    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            lru <= '0;
        end else if (write1 || write2) begin
            lru[set] <= write1;
        end
    end

endmodule

//--- rtl/fillMerge.sv
// Store word selection for the cache ways
// Bus word on refill, otherwise CPU bytes merged over the current word

`timescale 1ns/1ps

module fillMerge (
    input  logic               fillSelect,
    input  cachePkg::wordT     busWord,
    input  cachePkg::wordT     cpuWord,
    input  cachePkg::wordT     oldWord,
    input  cachePkg::byteMaskT byteMask,
    output cachePkg::wordT     storeWord
);

    import cachePkg::*;

    wordT mergedWord;

    // Byte lane merge
    always_comb begin
        mergedWord = oldWord;
        for (int i = 0; i < 4; i++) begin
            // Enabled lanes come from the core
            if (byteMask[i]) begin
                mergedWord[8*i +: 8] = cpuWord[8*i +: 8];
            end
        end
    end

    // Refill takes the whole bus word
    assign storeWord = fillSelect ? busWord : mergedWord;

endmodule

//--- rtl/cacheController.sv
// Data cache controller
// Miss sequencing through write-back and refill, beat counting and core stall

`timescale 1ns/1ps

module cacheController (
    input  logic             clk,
    input  logic             reset,
    input  logic             memRead,
    input  logic             memWrite,
    input  logic             hit,
    input  logic             victimDirty,
    input  logic             busReady,
    output logic             stall,
    output logic             busRequest,
    output logic             busWrite,
    output logic             cacheWriteEnable,
    output logic             fillSelect,
    output logic             readFromBus,
    output cachePkg::offsetT beat
);

    import cachePkg::*;

    localparam offsetT lastBeat = offsetT'(wordsPerBlock - 1);

    cacheStateT state;
    cacheStateT nextState;
    logic request;
    logic lastReady;

    assign request   = memRead || memWrite;
    // Final word of a block transfer
    assign lastReady = busReady && (beat == lastBeat);

    // ------------------------------------------------------------------------
    // State register and beat counter
    // ------------------------------------------------------------------------

    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            state <= idle;
        end else begin
            state <= nextState;
        end
    end

    // Advances on ready beats and wraps to 0 after the last one
    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            beat <= '0;
        end else if (busRequest && busReady) begin
            beat <= beat + 1'b1;
        end
    end

    // ------------------------------------------------------------------------
    // Next state and outputs
    // ------------------------------------------------------------------------

    always_comb begin
        nextState        = state;
        stall            = 1'b0;
        busRequest       = 1'b0;
        busWrite         = 1'b0;
        cacheWriteEnable = 1'b0;
        fillSelect       = 1'b0;
        readFromBus      = 1'b0;
        case (state)
            idle: begin
                if (request && !hit) begin
                    // Miss holds the core
                    stall = 1'b1;
                    nextState = victimDirty ? writeBack : fill;
                end else begin
                    // Hit store lands on the next edge
                    cacheWriteEnable = memWrite && hit;
                end
            end
            writeBack: begin
                stall      = 1'b1;
                busRequest = 1'b1;
                busWrite   = 1'b1;
                if (lastReady) begin
                    nextState = fill;
                end
            end
            fill: begin
                stall            = 1'b1;
                busRequest       = 1'b1;
                fillSelect       = 1'b1;
                readFromBus      = 1'b1;
                // One cache word per returned bus word
                cacheWriteEnable = busReady;
                if (lastReady) begin
                    nextState = finish;
                end
            end
            finish: begin
                // Access now hits and a store goes in with its mask
                cacheWriteEnable = memWrite;
                nextState = idle;
            end
            default: begin
                nextState = idle;
            end
        endcase
    end

endmodule

//--- rtl/dataCache.sv
// Two-way write-back data cache top level
// Connects control, ways, replacement and merge, and forms bus address and read data

`timescale 1ns/1ps

module dataCache (
    input  logic               clk,
    input  logic               reset,
    input  cachePkg::addrT     addr,
    input  cachePkg::wordT     writeData,
    input  cachePkg::byteMaskT byteMask,
    input  logic               memRead,
    input  logic               memWrite,
    output cachePkg::wordT     readData,
    output logic               stall,
    output logic               busRequest,
    output logic               busWrite,
    output cachePkg::addrT     busAddr,
    output cachePkg::wordT     busWriteData,
    input  cachePkg::wordT     busReadData,
    input  logic               busReady
);

    import cachePkg::*;

    // Address fields
    tagT    addrTag;
    setT    set;
    offsetT addrOffset;

    logic   hit, hitWay1, way1En, way2En, victimDirty;
    tagT    victimTag;
    logic   cacheWriteEnable, fillSelect, readFromBus;
    offsetT beat;
    offsetT wordSel;
    logic   way1We, way2We;
    logic   valid1, valid2, dirty1, dirty2;
    tagT    tag1, tag2;
    wordT   word1, word2;
    wordT   storeWord;

    assign addrTag    = addr[31 -: tagBits];
    assign set        = addr[2 + offsetBits +: setBits];
    assign addrOffset = addr[2 +: offsetBits];

    // Beat drives the word select while the bus is busy
    assign wordSel = busRequest ? beat : addrOffset;

    // Only the chosen way takes the write
    assign way1We = cacheWriteEnable && way1En;
    assign way2We = cacheWriteEnable && way2En;

    // ------------------------------------------------------------------------
    // Blocks
    // ------------------------------------------------------------------------

    cacheController ctrl_i (
        .clk(clk), .reset(reset), .memRead(memRead), .memWrite(memWrite),
        .hit(hit), .victimDirty(victimDirty), .busReady(busReady), .stall(stall),
        .busRequest(busRequest), .busWrite(busWrite), .cacheWriteEnable(cacheWriteEnable),
        .fillSelect(fillSelect), .readFromBus(readFromBus), .beat(beat)
    );

    cacheWay way1_i (
        .clk(clk), .reset(reset), .set(set), .wordSel(wordSel), .writeEnable(way1We),
        .fillWrite(fillSelect), .markDirty(memWrite), .newTag(addrTag),
        .storeWord(storeWord), .byteMask(byteMask), .valid(valid1), .dirty(dirty1),
        .tag(tag1), .word(word1)
    );

    cacheWay way2_i (
        .clk(clk), .reset(reset), .set(set), .wordSel(wordSel), .writeEnable(way2We),
        .fillWrite(fillSelect), .markDirty(memWrite), .newTag(addrTag),
        .storeWord(storeWord), .byteMask(byteMask), .valid(valid2), .dirty(dirty2),
        .tag(tag2), .word(word2)
    );

    wayReplace replace_i (
        .clk(clk), .reset(reset), .set(set), .addrTag(addrTag), .tag1(tag1), .tag2(tag2),
        .valid1(valid1), .valid2(valid2), .dirty1(dirty1), .dirty2(dirty2),
        .write1(way1We), .write2(way2We), .hit(hit), .hitWay1(hitWay1),
        .way1En(way1En), .way2En(way2En), .victimDirty(victimDirty), .victimTag(victimTag)
    );

    // Old word from the way being written
    fillMerge merge_i (
        .fillSelect(fillSelect), .busWord(busReadData), .cpuWord(writeData),
        .oldWord(way1En ? word1 : word2), .byteMask(byteMask), .storeWord(storeWord)
    );

    // ------------------------------------------------------------------------
    // Bus and core outputs
    // ------------------------------------------------------------------------

    // Victim block on write-back, requested block on fill
    assign busAddr = busWrite ? {victimTag, set, beat, 2'b00} : {addrTag, set, beat, 2'b00};
    assign busWriteData = way1En ? word1 : word2;

    assign readData = readFromBus ? busReadData : (hitWay1 ? word1 : word2);

endmodule

//--- verification/dataCacheAssertions.sv
// Bus and stall protocol checker for the data cache
// Bound into the top level

`timescale 1ns/1ps

module dataCacheAssertions (
    input logic           clk,
    input logic           reset,
    input logic           memRead,
    input logic           memWrite,
    input logic           hit,
    input logic           stall,
    input logic           busRequest,
    input logic           busWrite,
    input cachePkg::addrT busAddr
);

    import cachePkg::*;

    // Lowest address bit above the block offset
    localparam int blockLsb = 2 + offsetBits;

    writeNeedsRequest: assert property (@(posedge clk) disable iff (reset)
        busWrite |-> busRequest)
        else $error("busWrite high without busRequest");

    // Outside a transfer, stall only on a miss
    stallOnlyOnMiss: assert property (@(posedge clk) disable iff (reset)
        !busRequest |-> (stall == ((memRead || memWrite) && !hit)))
        else $error("stall does not match a pending miss while the bus is idle");

    // Same block while the direction holds
    addrInBlock: assert property (@(posedge clk) disable iff (reset)
        busRequest && $past(busRequest) && (busWrite == $past(busWrite))
        |-> busAddr[31:blockLsb] == $past(busAddr[31:blockLsb]))
        else $error("busAddr left its block during a transfer");

endmodule

bind dataCache dataCacheAssertions assertions_i (
    .clk(clk), .reset(reset), .memRead(memRead), .memWrite(memWrite), .hit(hit),
    .stall(stall), .busRequest(busRequest), .busWrite(busWrite), .busAddr(busAddr)
);

//--- verification/dataCacheTb.sv
// Testbench for the two-way write-back data cache
// LFSR accesses checked against a reference memory and cache model, with a bus memory

`timescale 1ns/1ps

module dataCacheTb;

    import cachePkg::*;

    localparam int memWords = 64;
    localparam int maxWait = 200;
    localparam int numAccesses = 400;

    logic     clk, reset, memRead, memWrite, stall, busRequest, busWrite, busReady;
    addrT     addr, busAddr;
    wordT     writeData, readData, busWriteData, busReadData;
    byteMaskT byteMask;

    logic [31:0] lfsrState;
    logic        hitSeen;
    // Bus side memory and architectural memory
    wordT busMem [memWords];
    wordT refMem [memWords];
    // Reference cache state, way index 0 is way 1
    logic refValid [numSets][2];
    logic refDirty [numSets][2];
    tagT  refTag [numSets][2];
    logic refLru [numSets];

    dataCache dut_i (
        .clk(clk), .reset(reset), .addr(addr), .writeData(writeData), .byteMask(byteMask),
        .memRead(memRead), .memWrite(memWrite), .readData(readData), .stall(stall),
        .busRequest(busRequest), .busWrite(busWrite), .busAddr(busAddr),
        .busWriteData(busWriteData), .busReadData(busReadData), .busReady(busReady)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ------------------------------------------------------------------------
    // Random numbers and helpers
    // ------------------------------------------------------------------------

    // Fibonacci taps 32, 22, 2, 1
    function automatic logic lfsrBit();
        logic fb;
        fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
        lfsrState = {lfsrState[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] randBits(input int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            value = {value[30:0], lfsrBit()};
        end
        return value;
    endfunction

    function automatic addrT makeAddr(input int tagSel, input int setSel, input int word);
        return {tagT'(tagSel), setT'(setSel), offsetT'(word), 2'b00};
    endfunction

    // Store semantics, enabled bytes only
    function automatic wordT mergeBytes(input wordT oldWord, input wordT newWord,
                                        input byteMaskT mask);
        wordT result;
        result = oldWord;
        for (int i = 0; i < 4; i++) begin
            if (mask[i]) begin
                result[8*i +: 8] = newWord[8*i +: 8];
            end
        end
        return result;
    endfunction

    task automatic stopRun();
        $display("** FAIL **");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic checkWord(input string name, input wordT expected, input wordT actual);
        if (actual !== expected) begin
            $display("FAIL %s: expected %h, actual %h", name, expected, actual);
            stopRun();
        end
    endtask

    task automatic checkAddr(input string name, input addrT expected, input addrT actual);
        if (actual !== expected) begin
            $display("FAIL %s: expected %h, actual %h", name, expected, actual);
            stopRun();
        end
    endtask

    task automatic checkFlag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("FAIL %s: expected %b, actual %b", name, expected, actual);
            stopRun();
        end
    endtask

    // ------------------------------------------------------------------------
    // Access sequencing
    // ------------------------------------------------------------------------

    // Falling edge, bus memory answers at the current bus address
    task automatic nextCycle();
        @(negedge clk);
        busReady = lfsrBit();
        busReadData = busMem[busAddr[7:2]];
    endtask

    task automatic runAccess(input logic isWrite, input addrT a, input wordT data,
                             input byteMaskT mask, output logic sawHit);
        setT        s;
        tagT        t;
        logic [5:0] index;
        logic       way;
        logic       expectHit;
        logic       expectWriteBack;
        tagT        victimTag;
        addrT       beatAddr;
        int         writes;
        int         reads;
        int         cycles;
        s = a[4];
        t = a[31:5];
        index = a[7:2];
        expectHit = 1'b1;
        // Hit way, then the single empty way, then LRU
        if (refValid[s][0] && refTag[s][0] == t) begin
            way = 1'b0;
        end else if (refValid[s][1] && refTag[s][1] == t) begin
            way = 1'b1;
        end else begin
            expectHit = 1'b0;
            way = (refValid[s][0] != refValid[s][1]) ? refValid[s][0] : refLru[s];
        end
        expectWriteBack = !expectHit && refValid[s][way] && refDirty[s][way];
        victimTag = refTag[s][way];
        nextCycle();
        addr = a;
        writeData = data;
        byteMask = mask;
        memWrite = isWrite;
        memRead = !isWrite;
        #2;
        sawHit = !stall;
        checkFlag("stall in request cycle", !expectHit, stall);
        checkFlag("busRequest in request cycle", 1'b0, busRequest);
        writes = 0;
        reads = 0;
        cycles = 0;
        while (stall) begin
            cycles++;
            if (cycles > maxWait) begin
                $display("Timeout: access to %h still stalled after %0d cycles", a, maxWait);
                stopRun();
            end
            nextCycle();
            #2;
            if (busRequest && busReady && busWrite) begin
                if (!expectWriteBack) begin
                    $display("Bus write at %h on a miss with a clean victim", busAddr);
                    stopRun();
                end
                beatAddr = {victimTag, s, offsetT'(writes), 2'b00};
                checkAddr("write-back address", beatAddr, busAddr);
                checkWord("write-back data", refMem[beatAddr[7:2]], busWriteData);
                busMem[busAddr[7:2]] = busWriteData;
                writes++;
            end else if (busRequest && busReady) begin
                checkAddr("fill address", {a[31:4], offsetT'(reads), 2'b00}, busAddr);
                reads++;
            end
        end
        if (!expectHit && (reads != 4 || writes != (expectWriteBack ? 4 : 0))) begin
            $display("Miss at %h moved %0d write and %0d read beats", a, writes, reads);
            stopRun();
        end
        if (!isWrite) begin
            checkWord("read data", refMem[index], readData);
        end
        // Model update, LRU follows every way write
        if (!expectHit) begin
            refValid[s][way] = 1'b1;
            refDirty[s][way] = 1'b0;
            refTag[s][way] = t;
            refLru[s] = !way;
        end
        if (isWrite) begin
            refMem[index] = mergeBytes(refMem[index], data, mask);
            refDirty[s][way] = 1'b1;
            refLru[s] = !way;
        end
    endtask

    // ------------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------------

    initial begin
        int       tagSel;
        int       setSel;
        int       wordSel;
        logic     isWrite;
        wordT     data;
        byteMaskT mask;
        lfsrState = 32'hab42;
        reset = 1'b1;
        addr = '0;
        writeData = '0;
        byteMask = '0;
        memRead = 1'b0;
        memWrite = 1'b0;
        busReadData = '0;
        busReady = 1'b0;
        for (int i = 0; i < memWords; i++) begin
            // Pattern over the whole byte address
            busMem[i] = ((32'(i) << 2) * 32'h9e37_79b1) ^ 32'h5a00_c3a5;
            refMem[i] = busMem[i];
        end
        for (int s = 0; s < numSets; s++) begin
            refLru[s] = 1'b0;
            for (int w = 0; w < 2; w++) begin
                refValid[s][w] = 1'b0;
                refDirty[s][w] = 1'b0;
                refTag[s][w] = '0;
            end
        end
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        #2;
        checkFlag("stall after reset", 1'b0, stall);
        checkFlag("busRequest after reset", 1'b0, busRequest);

        // LRU sequence in set 1, the store touch moves the LRU bit
        runAccess(1'b0, makeAddr(0, 1, 0), '0, '0, hitSeen);
        checkFlag("first access to tag 0", 1'b0, hitSeen);
        runAccess(1'b0, makeAddr(1, 1, 2), '0, '0, hitSeen);
        checkFlag("first access to tag 1", 1'b0, hitSeen);
        runAccess(1'b1, makeAddr(0, 1, 1), 32'h1234_5678, 4'b0110, hitSeen);
        checkFlag("store touch of tag 0", 1'b1, hitSeen);
        runAccess(1'b0, makeAddr(2, 1, 3), '0, '0, hitSeen);
        checkFlag("third tag in set 1", 1'b0, hitSeen);
        runAccess(1'b0, makeAddr(0, 1, 1), '0, '0, hitSeen);
        checkFlag("touched tag kept", 1'b1, hitSeen);
        runAccess(1'b0, makeAddr(1, 1, 0), '0, '0, hitSeen);
        checkFlag("untouched tag evicted", 1'b0, hitSeen);

        // Random traffic over three tags per set
        for (int n = 0; n < numAccesses; n++) begin
            tagSel = int'(randBits(2) % 3);
            setSel = int'(randBits(1));
            wordSel = int'(randBits(2));
            isWrite = lfsrBit();
            data = randBits(32);
            mask = byteMaskT'(randBits(4));
            runAccess(isWrite, makeAddr(tagSel, setSel, wordSel), data, mask, hitSeen);
        end

        @(negedge clk);
        memRead = 1'b0;
        memWrite = 1'b0;
        repeat (2) @(posedge clk);
        $display("** PASS **");
        $finish;
    end

endmodule

//--- sim.f
rtl/cachePkg.sv
rtl/cacheWay.sv
rtl/wayReplace.sv
rtl/fillMerge.sv
rtl/cacheController.sv
rtl/dataCache.sv
verification/dataCacheAssertions.sv
verification/dataCacheTb.sv

//--- run.sh
#!/bin/sh
# Build and run the data cache testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module dataCacheTb -f sim.f -o dataCacheSim
./obj_dir/dataCacheSim > sim.log 2>&1 || true
cat sim.log

if grep -q '^\*\* PASS \*\*$' sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi
